/* common/vid_pkg.sv */
// video timing side of the sprite path
// raster position from the board timing chain and the per-pixel
// sprite output handed on to colour mixing
package vid_pkg;

    // 8-pixel columns across a 256-pixel line, blanking included
    localparam int COLUMNS = 32;

    // raster position, one step per pixel clock enable
    typedef struct packed {
        logic [7:0] h;          // 0..255, wraps once per line
        logic [7:0] v;          // steps when h wraps
        logic       line_start; // high while h is 0
    } raster_t;

    // sprite pixel towards the mixer
    typedef struct packed {
        logic        valid;    // object pixel present
        logic [2:0]  pal;      // object palette
        logic [13:0] rom_addr; // bank, id, row, column
        logic        bank_hi;  // spare, kept at 0
    } obj_pix_t;

endpackage

/* common/obj_pkg.sv */
// object side definitions
// attribute table word, line buffer slot, APB bundles and
// the register map of the CPU port
package obj_pkg;

    // table entry, low 29 bits of an APB data word
    typedef struct packed {
        logic       bank;  // bit 28, pattern bank
        logic       vflip; // bit 27
        logic [2:0] pal;   // bits 26:24
        logic       hflip; // bit 23
        logic [6:0] id;    // bits 22:16, pattern number
        logic [7:0] y;     // bits 15:8, top line
        logic [7:0] x;     // bits 7:0, only x[7:3] counts
    } obj_attr_t;

    // one column slot of the line buffer
    typedef struct packed {
        logic       valid;
        logic       bank;
        logic [6:0] id;
        logic [2:0] pal;
        logic       hflip;
        logic [2:0] row;   // vflip already applied
    } line_entry_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [9:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    localparam logic [7:0] CTRL_INDEX = 8'd127; // word index of control reg, bit 0 obj_en
    localparam int         OBJ_ROWS   = 8;      // object height in lines

endpackage

/* design/obj_ram.sv */
// simple dual-port synchronous RAM
// one write port, one read port with a registered output
// word type chosen by the instance, shared by the attribute
// table and the two line buffer banks
`timescale 1ns/100ps

module obj_ram #(
    parameter int  DEPTH     = 32,
    parameter type payload_t = logic [7:0],
    localparam int AW        = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
    input  logic          clk,
    input  logic          we,
    input  logic [AW-1:0] waddr,
    input  logic [AW-1:0] raddr,
    input  payload_t      wdata,
    output payload_t      rdata
);

    payload_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        rdata <= mem[raddr]; // old word on a same-address write
    end

    // callers must keep their address maps inside the array
    a_waddr_range: assert property (@(posedge clk) we |-> waddr < DEPTH)
        else $error("obj_ram: write address %0d beyond depth %0d", waddr, DEPTH);

    a_raddr_range: assert property (@(posedge clk) raddr < DEPTH)
        else $error("obj_ram: read address %0d beyond depth %0d", raddr, DEPTH);

endmodule

/* obj_table/obj_table_apb.sv */
// object attribute table with its APB slave
// CPU writes attribute words and the control register, the
// scan stage reads the table through the second RAM port
// zero wait states, response registered in the setup phase
`timescale 1ns/100ps

module obj_table_apb #(
    parameter int OBJ_COUNT = 32
) (
    input  logic               clk,
    input  logic               reset,
    input  obj_pkg::apb_req_t  apb_req,
    output obj_pkg::apb_rsp_t  apb_rsp,
    input  logic [6:0]         scan_addr,
    output obj_pkg::obj_attr_t scan_attr,
    output logic               obj_en
);
    import obj_pkg::*;

    localparam int AW = (OBJ_COUNT > 1) ? $clog2(OBJ_COUNT) : 1;

    logic [7:0]  widx;      // word index
    logic        setup;     // first cycle of a transfer
    logic        access;    // second cycle, completes with pready
    logic        hit_tbl;
    logic        hit_ctrl;
    logic        err;
    logic        tbl_we;
    logic [31:0] prdata_q;
    logic        pslverr_q;
    obj_attr_t   wr_attr;

    if (OBJ_COUNT < 1 || OBJ_COUNT > 127) begin : g_count_check
        $error("obj_table_apb: OBJ_COUNT %0d outside 1..127", OBJ_COUNT);
    end

    assign widx     = apb_req.paddr[9:2];
    assign setup    = apb_req.psel & ~apb_req.penable;
    assign access   = apb_req.psel & apb_req.penable;
    assign hit_tbl  = widx < OBJ_COUNT;
    assign hit_ctrl = widx == CTRL_INDEX;
    // table is write only, ctrl is read/write, rest is a hole
    assign err      = ~(hit_ctrl | (apb_req.pwrite & hit_tbl));
    assign tbl_we   = access & apb_req.pwrite & hit_tbl;
    assign wr_attr  = apb_req.pwdata[28:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            obj_en    <= 1'b0;
            pslverr_q <= 1'b0;
        end else begin
            if (setup) begin
                pslverr_q <= err;  // ready for the access phase
            end else if (access) begin
                pslverr_q <= 1'b0;
            end
            if (access && apb_req.pwrite && hit_ctrl) begin
                obj_en <= apb_req.pwdata[0];
            end
        end
    end

    // read data, only the control register reads back
    always_ff @(posedge clk) begin
        if (setup) begin
            prdata_q <= (!apb_req.pwrite && hit_ctrl) ? {31'd0, obj_en} : 32'd0;
        end
    end

    assign apb_rsp = '{prdata: prdata_q, pready: 1'b1, pslverr: pslverr_q};

    obj_ram #(
        .DEPTH     (OBJ_COUNT),
        .payload_t (obj_attr_t)
    ) u_table (
        .clk   (clk),
        .we    (tbl_we),
        .waddr (widx[AW-1:0]),
        .raddr (scan_addr[AW-1:0]), // scan holds it below OBJ_COUNT
        .wdata (wr_attr),
        .rdata (scan_attr)
    );

    // registered response needs a setup cycle before every access
    a_apb_setup: assert property (@(posedge clk) disable iff (reset)
        $rose(apb_req.penable) |-> apb_req.psel && $past(apb_req.psel))
        else $error("obj_table_apb: penable without a setup phase");

endmodule

/* obj_scan/obj_scan.sv */
// per-line object scan
// walks the attribute table two pixels per object, tests each
// object against the next line and emits line buffer writes
// with the vflip-corrected row
`timescale 1ns/100ps

module obj_scan #(
    parameter int OBJ_COUNT = 32
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 pxl_cen,
    input  vid_pkg::raster_t     raster,
    input  logic                 obj_en,
    output logic [6:0]           scan_addr,
    input  obj_pkg::obj_attr_t   scan_attr,
    output logic                 wr_en,
    output logic [4:0]           wr_col,
    output obj_pkg::line_entry_t wr_entry
);
    import obj_pkg::*;

    logic       line_en;   // obj_en as it stood at line start
    logic [6:0] idx;       // object under scan
    logic       in_range;
    logic [7:0] next_v;
    logic [7:0] dy;        // line offset inside the object
    logic [8:0] zone_chk;
    logic       in_zone;

    // the whole table must fit inside one line
    if (2 * OBJ_COUNT > 256) begin : g_count_check
        $error("obj_scan: %0d objects do not fit in a line", OBJ_COUNT);
    end

    assign idx       = raster.h[7:1];           // even h reads, odd h tests
    assign in_range  = idx < OBJ_COUNT;
    assign scan_addr = in_range ? idx : 7'd0;   // park on entry 0 afterwards

    always_ff @(posedge clk) begin
        if (reset) begin
            line_en <= 1'b0;
        end else if (pxl_cen && raster.line_start) begin
            line_en <= obj_en;
        end
    end

    // in-zone test, n - y below the object height
    assign next_v   = raster.v + 8'd1;
    assign dy       = next_v - scan_attr.y;     // mod 256
    assign zone_chk = {1'b0, dy} - 9'(OBJ_ROWS);
    assign in_zone  = zone_chk[8];              // borrow out means inside

    assign wr_en  = pxl_cen & raster.h[0] & in_range & line_en & in_zone;
    assign wr_col = scan_attr.x[7:3];           // x[2:0] ignored

    always_comb begin
        wr_entry       = '0;
        wr_entry.valid = 1'b1;
        wr_entry.bank  = scan_attr.bank;
        wr_entry.id    = scan_attr.id;
        wr_entry.pal   = scan_attr.pal;
        wr_entry.hflip = scan_attr.hflip;
        wr_entry.row   = dy[2:0] ^ {3{scan_attr.vflip}}; // upside down
    end

endmodule

/* obj_linebuf/obj_linebuf.sv */
// ping-pong object line buffer
// scan fills the bank of the next line while the bank of the
// current line is read column by column and cleared behind
// the read, so it starts empty when its turn to fill comes
// valid is held off until both banks have been swept
`timescale 1ns/100ps

module obj_linebuf (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 pxl_cen,
    input  vid_pkg::raster_t     raster,
    input  logic                 wr_en,
    input  logic [4:0]           wr_col,
    input  obj_pkg::line_entry_t wr_entry,
    output obj_pkg::line_entry_t rd_entry
);
    import obj_pkg::*;
    import vid_pkg::*;

    logic        disp_bank;  // bank shown this line
    logic        scan_bank;  // bank being filled for line v + 1
    logic [4:0]  rd_col;
    logic        clr_we;
    logic        clr_bank;   // bank and column of the last read
    logic [4:0]  clr_col;
    logic [1:0]  warm;       // line starts seen since reset
    line_entry_t bank_q [2];
    line_entry_t raw;

    assign disp_bank = raster.v[0];
    assign scan_bank = ~raster.v[0];  // n = v + 1
    assign rd_col    = raster.h[7:3];
    assign clr_we    = pxl_cen && raster.h[2:0] == 3'd1; // entry leaves, slot emptied

    // remember what was addressed, the clear follows one enable later
    always_ff @(posedge clk) begin
        if (pxl_cen && raster.h[2:0] == 3'd0) begin
            clr_bank <= disp_bank;
            clr_col  <= rd_col;
        end
    end

    for (genvar b = 0; b < 2; b++) begin : g_bank
        logic        is_clr;
        logic        we;
        logic [4:0]  waddr;
        line_entry_t wdata;

        assign is_clr = clr_we && clr_bank == 1'(b);
        assign we     = is_clr || (wr_en && scan_bank == 1'(b));
        assign waddr  = is_clr ? clr_col : wr_col;
        assign wdata  = is_clr ? line_entry_t'('0) : wr_entry;

        obj_ram #(
            .DEPTH     (COLUMNS),
            .payload_t (line_entry_t)
        ) u_bank (
            .clk   (clk),
            .we    (we),
            .waddr (waddr),
            .raddr (rd_col),   // both banks read, one is picked
            .wdata (wdata),
            .rdata (bank_q[b])
        );
    end

    // reset line plus two full lines before both banks are clean
    always_ff @(posedge clk) begin
        if (reset) begin
            warm <= 2'd0;
        end else if (pxl_cen && raster.line_start && warm != 2'd3) begin
            warm <= warm + 2'd1;
        end
    end

    assign raw      = bank_q[disp_bank];
    assign rd_entry = (raw.valid && warm == 2'd3) ? raw : line_entry_t'('0);

    // clear lags the read by one enable, must still miss the scan bank
    a_bank_split: assert property (@(posedge clk) disable iff (reset)
        clr_we && wr_en |-> clr_bank != scan_bank)
        else $error("obj_linebuf: scan write and clear hit bank %0d", clr_bank);

endmodule

/* obj_draw/obj_draw.sv */
// object column drawer
// takes one line buffer entry per 8-pixel column and spreads
// it over the next column slot as pattern ROM addresses,
// with hflip reversing the pixel order
`timescale 1ns/100ps

module obj_draw (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 pxl_cen,
    input  vid_pkg::raster_t     raster,
    input  obj_pkg::line_entry_t rd_entry,
    output vid_pkg::obj_pix_t    pix
);
    import obj_pkg::*;

    line_entry_t next_q;  // caught from the line buffer
    line_entry_t cur_q;   // column being drawn
    logic [2:0]  cnt;     // pixel inside the column
    logic [2:0]  col;     // pattern column after hflip

    always_ff @(posedge clk) begin
        if (reset) begin
            next_q <= '0;
            cur_q  <= '0;
            cnt    <= 3'd0;
        end else if (pxl_cen) begin
            if (raster.h[2:0] == 3'd1) begin
                next_q <= rd_entry;
            end
            if (raster.h[2:0] == 3'd7) begin
                cur_q <= next_q;  // drawn during the following 8 pixels
                cnt   <= 3'd0;    // realign with h[2:0]
            end else begin
                cnt <= cnt + 3'd1;
            end
        end
    end

    assign col = cnt ^ {3{cur_q.hflip}};

    always_comb begin
        pix = '0;
        if (cur_q.valid) begin
            pix.valid    = 1'b1;
            pix.pal      = cur_q.pal;
            pix.rom_addr = {cur_q.bank, cur_q.id, cur_q.row, col};
        end
    end

endmodule

/* design/obj_top.sv */
// sprite path top level
// APB attribute table, per-line scan, ping-pong line buffer and
// column drawer in a pipeline, output 8 pixel enables behind
// the raster
`timescale 1ns/100ps

module obj_top #(
    parameter int OBJ_COUNT = 32
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              pxl_cen,
    input  vid_pkg::raster_t  raster,
    input  obj_pkg::apb_req_t apb_req,
    output obj_pkg::apb_rsp_t apb_rsp,
    output vid_pkg::obj_pix_t pix
);
    import obj_pkg::*;

    logic        [6:0] scan_addr;
    obj_attr_t         scan_attr;
    logic              obj_en;
    logic              wr_en;
    logic        [4:0] wr_col;
    line_entry_t       wr_entry;
    line_entry_t       rd_entry;

    obj_table_apb #(.OBJ_COUNT(OBJ_COUNT)) u_table (
        .clk       (clk),
        .reset     (reset),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .scan_addr (scan_addr),
        .scan_attr (scan_attr),
        .obj_en    (obj_en)
    );

    obj_scan #(.OBJ_COUNT(OBJ_COUNT)) u_scan (
        .clk       (clk),
        .reset     (reset),
        .pxl_cen   (pxl_cen),
        .raster    (raster),
        .obj_en    (obj_en),
        .scan_addr (scan_addr),
        .scan_attr (scan_attr),
        .wr_en     (wr_en),
        .wr_col    (wr_col),
        .wr_entry  (wr_entry)
    );

    obj_linebuf u_linebuf (
        .clk      (clk),
        .reset    (reset),
        .pxl_cen  (pxl_cen),
        .raster   (raster),
        .wr_en    (wr_en),
        .wr_col   (wr_col),
        .wr_entry (wr_entry),
        .rd_entry (rd_entry)
    );

    obj_draw u_draw (
        .clk      (clk),
        .reset    (reset),
        .pxl_cen  (pxl_cen),
        .raster   (raster),
        .rd_entry (rd_entry),
        .pix      (pix)
    );

endmodule

/* verification/obj_tb.sv */
// testbench for the sprite path top level
// drives the raster and APB from the falling edge, keeps a model
// of the attribute table and of the line buffer contents per line,
// and checks every pixel and APB response with concurrent assertions
`timescale 1ns/100ps

module obj_tb;
    import obj_pkg::*;
    import vid_pkg::*;

    localparam int OBJ_COUNT = 32;
    localparam int LINE_CYCLES = 512;  // 256 enables, every other clock

    logic        clk;
    logic        reset;
    logic        pxl_cen;
    raster_t     raster;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    obj_pix_t    pix;

    obj_attr_t   tbl [OBJ_COUNT];      // table as the CPU wrote it
    logic        en_model;
    line_entry_t line_exp [4][32];     // expected slots, by line mod 4
    obj_pix_t    exp_pix;
    logic        exp_err;
    logic [31:0] exp_rdata;
    logic [31:0] lfsr;
    int          line_cnt;             // lines since reset, v does not wrap here
    int          reset_cycles;
    int          errors;
    int          timeouts;
    int          pix_checks;
    int          obj_pixels;           // pixels where an object was expected
    int          apb_checks;
    string       test_name;

    obj_top #(.OBJ_COUNT(OBJ_COUNT)) dut0 (
        .clk     (clk),
        .reset   (reset),
        .pxl_cen (pxl_cen),
        .raster  (raster),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .pix     (pix)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // galois lfsr, one step per bit
    function automatic logic [31:0] take_bits(input int count);
        logic [31:0] v;
        v = '0;
        for (int b = 0; b < count; b++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // slots of line n from the table and obj_en at the scan
    function automatic void build_line(input int line);
        logic [7:0]  dy;
        line_entry_t e;
        for (int c = 0; c < 32; c++) begin
            line_exp[line & 3][c] = '0;
        end
        for (int i = 0; i < OBJ_COUNT; i++) begin
            dy = 8'(line) - tbl[i].y;  // mod 256
            if (en_model && dy < 8'd8) begin
                e       = '0;
                e.valid = 1'b1;
                e.bank  = tbl[i].bank;
                e.id    = tbl[i].id;
                e.pal   = tbl[i].pal;
                e.hflip = tbl[i].hflip;
                e.row   = dy[2:0] ^ {3{tbl[i].vflip}};
                line_exp[line & 3][tbl[i].x[7:3]] = e;  // higher index wins
            end
        end
    endfunction

    // pixel h - 8, previous line for the first 8 positions
    function automatic obj_pix_t expect_pixel(input logic [7:0] h, input int line);
        obj_pix_t    p;
        line_entry_t e;
        logic [7:0]  ph;
        int          pline;
        ph    = h - 8'd8;
        pline = (h < 8'd8) ? line - 1 : line;
        e     = line_exp[pline & 3][ph[7:3]];
        p     = '0;
        if (e.valid) begin
            p.valid    = 1'b1;
            p.pal      = e.pal;
            p.rom_addr = {e.bank, e.id, e.row, ph[2:0] ^ {3{e.hflip}}};
        end
        return p;
    endfunction

    // reset release, then raster steps once per enable
    always @(negedge clk) begin
        if (reset) begin
            reset_cycles++;
            if (reset_cycles == 5) begin
                reset = 1'b0;
            end
        end else if (pxl_cen) begin
            pxl_cen  = 1'b0;
            raster.h = raster.h + 8'd1;
            if (raster.h == 8'd0) begin
                raster.v = raster.v + 8'd1;
                line_cnt++;
                build_line(line_cnt + 1);  // scan of this line fills the next
            end
            raster.line_start = (raster.h == 8'd0);
            exp_pix = expect_pixel(raster.h, line_cnt);
        end else begin
            pxl_cen = 1'b1;
        end
    end

    always @(posedge clk) begin
        if (!reset && pxl_cen) begin
            pix_checks++;
            if (exp_pix.valid) begin
                obj_pixels++;
            end
        end
    end

    a_pixel: assert property (@(posedge clk) disable iff (reset) pxl_cen |-> pix == exp_pix)
        else begin
            errors++;
            $display("FAIL %s line %0d h %0d expected %h actual %h",
                     test_name, line_cnt, raster.h, $sampled(exp_pix), $sampled(pix));
        end

    // access phase, zero wait states
    a_apb: assert property (@(posedge clk) disable iff (reset)
        apb_req.psel && apb_req.penable |-> apb_rsp.pready && apb_rsp.pslverr == exp_err
            && apb_rsp.prdata == exp_rdata)
        else begin
            errors++;
            $display("FAIL %s expected err %0b rdata %h actual err %0b rdata %h ready %0b",
                     test_name, exp_err, exp_rdata, $sampled(apb_rsp.pslverr),
                     $sampled(apb_rsp.prdata), $sampled(apb_rsp.pready));
        end

    task automatic finish_run();
        if (obj_pixels == 0) begin
            errors++;
            $display("no object pixel was ever expected, stimulus missed the draw path");
        end
        $display("pixel checks %0d, object pixels %0d, apb checks %0d, errors %0d, timeouts %0d",
                 pix_checks, obj_pixels, apb_checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    endtask

    task automatic wait_lines(input int lines);
        int target;
        int cycles;
        target = line_cnt + lines;
        cycles = 0;
        while (line_cnt < target) begin
            @(posedge clk);
            cycles++;
            if (cycles > lines * LINE_CYCLES + 64) begin
                timeouts++;
                $display("timeout while waiting for %0d line starts", lines);
                finish_run();
            end
        end
    endtask

    // one transfer, kept away from the scan at the start of the line
    task automatic apb_access(input logic write, input logic [7:0] index, input logic [31:0] data);
        int cycles;
        cycles = 0;
        @(posedge clk);
        while (raster.h < 8'd128 || raster.h > 8'd230) begin
            @(posedge clk);
            cycles++;
            if (cycles > LINE_CYCLES + 64) begin
                timeouts++;
                $display("timeout while waiting for the APB window");
                finish_run();
            end
        end
        @(negedge clk);
        exp_err   = !(index == CTRL_INDEX || (write && int'(index) < OBJ_COUNT));
        exp_rdata = (!write && index == CTRL_INDEX) ? {31'd0, en_model} : 32'd0;
        apb_req.psel    = 1'b1;       // setup
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = {index, 2'b00};
        apb_req.pwdata  = data;
        @(negedge clk);
        apb_req.penable = 1'b1;       // access, done on the next edge
        @(negedge clk);
        apb_req = '0;
        if (write && index == CTRL_INDEX) begin
            en_model = data[0];
        end else if (write && int'(index) < OBJ_COUNT) begin
            tbl[index[4:0]] = data[28:0];
        end
        apb_checks++;
    endtask

    task automatic put_obj(input int index, input logic [7:0] y, input logic [4:0] col,
                           input logic hflip, input logic vflip);
        obj_attr_t a;
        a.bank  = 1'(take_bits(1));
        a.vflip = vflip;
        a.pal   = 3'(take_bits(3));
        a.hflip = hflip;
        a.id    = 7'(take_bits(7));
        a.y     = y;
        a.x     = {col, 3'(take_bits(3))};  // low bits ignored by the DUT
        apb_access(1'b1, 8'(index), {3'b000, a});
    endtask

    initial begin
        int cycles;
        logic [7:0] y;
        clk_init: begin
            reset   = 1'b1;
            pxl_cen = 1'b0;
            raster  = '{h: 8'd0, v: 8'd0, line_start: 1'b1};
            apb_req = '0;
        end
        lfsr = 32'h6c;
        en_model = 1'b0;
        exp_pix = '0;
        exp_err = 1'b0;
        exp_rdata = '0;
        test_name = "reset";
        foreach (tbl[i]) begin
            tbl[i] = '0;
        end
        foreach (line_exp[l, c]) begin
            line_exp[l][c] = '0;
        end
        cycles = 0;
        while (reset) begin
            @(posedge clk);
            cycles++;
            if (cycles > 20) begin
                timeouts++;
                $display("timeout while waiting for reset release");
                finish_run();
            end
        end

        test_name = "disabled_full_table";
        y = 8'(line_cnt + 4);  // every object inside the lines waited for below
        for (int i = 0; i < OBJ_COUNT; i++) begin
            put_obj(i, y, 5'(i), 1'(take_bits(1)), 1'(take_bits(1)));
        end
        wait_lines(12);

        test_name = "apb_registers";
        apb_access(1'b1, CTRL_INDEX, 32'h1);
        apb_access(1'b0, CTRL_INDEX, 32'h0);
        apb_access(1'b1, CTRL_INDEX, 32'h0);
        apb_access(1'b0, CTRL_INDEX, 32'h0);
        apb_access(1'b0, 8'd3, 32'h0);             // table is write only
        apb_access(1'b1, 8'd64, take_bits(32));    // hole, no effect
        apb_access(1'b0, 8'd200, 32'h0);
        wait_lines(3);

        // park the whole table on lines 200..207
        for (int i = 0; i < OBJ_COUNT; i++) begin
            put_obj(i, 8'd200, 5'(i), 1'b0, 1'b0);
        end
        apb_access(1'b1, CTRL_INDEX, 32'h1);

        test_name = "single_object";
        put_obj(5, 8'(line_cnt + 3), 5'd9, 1'b0, 1'b0);
        wait_lines(14);

        test_name = "flips";
        for (int round = 0; round < 2; round++) begin
            for (int f = 0; f < 4; f++) begin
                y = 8'(line_cnt + 3 + f);
                put_obj(10 + f, y, {2'(f), 3'(take_bits(3))}, f[0], f[1]);
            end
            wait_lines(15);
            for (int f = 0; f < 4; f++) begin
                put_obj(10 + f, 8'd200, 5'(10 + f), 1'b0, 1'b0);
            end
        end

        test_name = "same_column";
        y = 8'(line_cnt + 3);
        put_obj(3, y, 5'd17, 1'b0, 1'b0);
        put_obj(20, y + 8'd3, 5'd17, 1'b1, 1'b0);  // overlaps lines y+3..y+7
        wait_lines(16);
        put_obj(3, 8'd200, 5'd3, 1'b0, 1'b0);
        put_obj(20, 8'd200, 5'd20, 1'b0, 1'b0);

        test_name = "move_object";
        put_obj(9, 8'(line_cnt + 3), 5'd6, 1'b0, 1'b1);
        wait_lines(6);
        put_obj(9, 8'(line_cnt + 50), 5'd6, 1'b0, 1'b1);  // old lines must go
        wait_lines(5);
        put_obj(9, 8'd200, 5'd9, 1'b0, 1'b0);
        wait_lines(2);

        finish_run();
    end

endmodule

/* build.f */
common/vid_pkg.sv
common/obj_pkg.sv
design/obj_ram.sv
obj_table/obj_table_apb.sv
obj_scan/obj_scan.sv
obj_linebuf/obj_linebuf.sv
obj_draw/obj_draw.sv
design/obj_top.sv
verification/obj_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the sprite path testbench with Verilator, run it, judge the log
verilator --binary --timing --assert --top-module obj_tb -f build.f -o obj_sim > sim.log 2>&1 \
    && ./obj_dir/obj_sim >> sim.log 2>&1 \
    || { echo "build or run error, see sim.log"; exit 1; }
grep -q "Simulation finished: FAIL" sim.log && { echo "FAIL, see sim.log"; exit 1; } \
    || grep -q "Simulation finished: PASS" sim.log && echo "PASS" \
    || { echo "no result in sim.log"; exit 1; }
